// File: bench/gpio_tb_model.svh
/* Shadow model of the GPIO register file and interrupt status rules */

`ifndef GPIO_TB_MODEL_SVH
`define GPIO_TB_MODEL_SVH

   gpio_vec_t m_out;                             // OUT register
   gpio_vec_t m_dir;                             // DIR register
   gpio_vec_t m_mask;
   gpio_vec_t m_edge;
   gpio_vec_t m_pol;
   gpio_vec_t m_stat;                            // Sticky event status
   gpio_vec_t m_level;                           // Pin level behind the synchronizer

   // Level pins keep setting status while level equals polarity
   function automatic void model_level_events();
      for (int i = 0; i < NGPIO; i++) begin
         if (!m_edge[i] && m_level[i] == m_pol[i])
            m_stat[i] = 1'b1;
      end
   endfunction

   function automatic void model_reset();
      m_out   = '0;
      m_dir   = '0;
      m_mask  = '0;
      m_edge  = '0;
      m_pol   = '0;
      m_stat  = '0;
      m_level = '0;
      model_level_events();                      // Low pins match low polarity at once
   endfunction

   // New settled pin value
   function automatic void model_pins(input gpio_vec_t pins);
      for (int i = 0; i < NGPIO; i++) begin
         if (m_edge[i] && pins[i] != m_level[i] && pins[i] == m_pol[i])
            m_stat[i] = 1'b1;                    // Rise with POL 1, fall with POL 0
      end
      m_level = pins;
      model_level_events();
   endfunction

   // One bus access in issue order
   function automatic void model_access(input logic wr, input logic [ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] wdata,
                                        output logic [DATA_W-1:0] rdata,
                                        output gpio_resp_e err);
      gpio_vec_t bits;
      gpio_vec_t val;
      bits = wdata[NGPIO-1:0];                   // Only pin bits count
      val  = '0;
      err  = RESP_OK;
      if (wr) begin
         case (addr)
            OFF_OUT:      m_out  = bits;
            OFF_OUT_SET:  m_out  = m_out | bits;
            OFF_OUT_CLR:  m_out  = m_out & ~bits;
            OFF_OUT_XOR:  m_out  = m_out ^ bits;
            OFF_DIR:      m_dir  = bits;
            OFF_IRQ_MASK: m_mask = bits;
            OFF_IRQ_EDGE: m_edge = bits;
            OFF_IRQ_POL:  m_pol  = bits;
            OFF_IRQ_STAT: m_stat = m_stat & ~bits;   // W1C
            default:      err    = RESP_ERR;         // IN and unmapped
         endcase
         rdata = '0;
      end else begin
         case (addr)
            OFF_OUT:      val = m_out;
            OFF_DIR:      val = m_dir;
            OFF_IN:       val = m_level;
            OFF_IRQ_MASK: val = m_mask;
            OFF_IRQ_EDGE: val = m_edge;
            OFF_IRQ_POL:  val = m_pol;
            OFF_IRQ_STAT: val = m_stat;
            default:      err = RESP_ERR;        // Write-only and unmapped
         endcase
         rdata            = '0;                  // Upper bits read zero
         rdata[NGPIO-1:0] = val;
      end
      model_level_events();                      // Level match wins over a clear
   endfunction

`endif

// File: bench/gpio_top_tb.sv
/* GPIO controller testbench: random bus traffic, pin changes, stalls and
   interrupt checks against a shadow model */

`timescale 1ns/1ps

module gpio_top_tb
   import gpio_reg_pkg::*, gpio_bus_pkg::*;
   ();

   localparam int          N_SERIAL    = 200;   // One access at a time
   localparam int          N_STALL     = 200;   // Back to back, random rsp_ready
   localparam int          N_TIMED     = 100;   // Back to back, rsp_ready high
   localparam int          CLK_NS      = 20;
   localparam int          WATCHDOG_NS = 20 * (N_SERIAL + N_STALL + N_TIMED) * CLK_NS;
   localparam logic [31:0] SEED        = 32'd68;

   logic              sys_clk;
   logic              arst_n;
   logic              req_valid;
   logic              req_ready;
   logic              req_write;
   logic [ADDR_W-1:0] req_addr;
   logic [DATA_W-1:0] req_wdata;
   logic              rsp_valid;
   logic              rsp_ready;
   logic [DATA_W-1:0] rsp_rdata;
   logic              rsp_err;
   gpio_vec_t         gpio_in;
   gpio_vec_t         gpio_out;
   gpio_vec_t         gpio_oe;
   logic              gpio_irq;

   logic [31:0]       rng_state;                 // Main stimulus stream
   logic [31:0]       stall_state;               // rsp_ready stream
   logic              stall_en;
   logic              timed;                     // Check fixed latency
   int unsigned       cyc;                       // Rising edges seen
   logic [DATA_W-1:0] exp_data_q [$];
   gpio_resp_e        exp_err_q  [$];
   int unsigned       launch_q   [$];            // cyc at each request handshake
   logic              hold_pending;
   logic [DATA_W-1:0] hold_data;
   gpio_resp_e        hold_err;

   `include "gpio_tb_model.svh"

   gpio_top uut (.*);

   always #(CLK_NS/2) sys_clk = ~sys_clk;

   always @(posedge sys_clk) cyc <= cyc + 1;

   //########################################
   // Random numbers and checks
   //########################################
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check_rsp(input logic [DATA_W-1:0] got_data, input gpio_resp_e got_err,
                            input logic [DATA_W-1:0] exp_data, input gpio_resp_e exp_err);
      if (got_data !== exp_data) begin
         $display("Error: rsp_rdata got %h expected %h", got_data, exp_data);
         abort_run();
      end else if (got_err !== exp_err) begin
         $display("Error: rsp_err got %h expected %h", got_err, exp_err);
         abort_run();
      end
   endtask

   task automatic check_pins(input gpio_vec_t got, input gpio_vec_t exp, input string name);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: gpio_irq got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   //########################################
   // Response monitor
   //########################################
   task automatic take_rsp();
      int unsigned t;
      if (exp_data_q.size() == 0) begin
         $display("A response arrived with no request outstanding");
         abort_run();
      end else begin
         check_rsp(rsp_rdata, gpio_resp_e'(rsp_err), exp_data_q.pop_front(),
                   exp_err_q.pop_front());
         t = launch_q.pop_front();
         if (timed && cyc != t + 2) begin
            $display("Response came %0d edges after the request, not 2", cyc - t);
            abort_run();
         end
      end
   endtask

   // Sampled at the falling edge, between drive and capture
   always @(negedge sys_clk) begin
      if (hold_pending && !rsp_valid) begin
         $display("Response was withdrawn while rsp_ready was low");
         abort_run();
      end else if (hold_pending) begin
         check_rsp(rsp_rdata, gpio_resp_e'(rsp_err), hold_data, hold_err);
      end
      hold_pending = rsp_valid & ~rsp_ready;
      hold_data    = rsp_rdata;
      hold_err     = gpio_resp_e'(rsp_err);
      if (req_valid && req_ready)
         launch_q.push_back(cyc);
      if (rsp_valid && rsp_ready)
         take_rsp();
   end

   always @(posedge sys_clk) begin
      #2;
      stall_state = xorshift(stall_state);
      rsp_ready   = stall_en ? stall_state[0] : 1'b1;   // Half the cycles stall
   end

   //########################################
   // Stimulus
   //########################################
   task automatic send_req(input logic wr, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata);
      logic [DATA_W-1:0] d;
      gpio_resp_e        e;
      model_access(wr, addr, wdata, d, e);
      exp_data_q.push_back(d);
      exp_err_q.push_back(e);
      req_valid = 1'b1;
      req_write = wr;
      req_addr  = addr;
      req_wdata = wdata;
      @(negedge sys_clk);
      while (!req_ready)
         @(negedge sys_clk);
      @(posedge sys_clk);
      #2;
      req_valid = 1'b0;
   endtask

   // Wait for every outstanding response, end 2 ns past an edge
   task automatic drain();
      while (exp_data_q.size() != 0)
         @(posedge sys_clk);
      @(posedge sys_clk);
      #2;
   endtask

   task automatic change_pins(input gpio_vec_t pins);
      model_pins(pins);
      gpio_in = pins;
      repeat (4) @(posedge sys_clk);             // Sync, edge and status settle
      #2;
   endtask

   task automatic stream_one();
      logic [31:0]       r;
      logic [ADDR_W-1:0] addr;
      r    = next_rand();
      addr = r[3:0];
      if (!r[4] && addr == OFF_IRQ_STAT)
         addr = OFF_IRQ_MASK;                    // Status read only on a quiet bus
      send_req(r[4], addr, next_rand());
   endtask

   initial begin
      logic [31:0] r;
      sys_clk      = 1'b0;
      arst_n       = 1'b0;
      req_valid    = 1'b0;
      req_write    = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      rsp_ready    = 1'b1;
      gpio_in      = '0;
      rng_state    = SEED;
      stall_state  = xorshift(~SEED);
      stall_en     = 1'b0;
      timed        = 1'b0;
      cyc          = 0;
      hold_pending = 1'b0;
      model_reset();
      repeat (2) @(posedge sys_clk);
      #2;
      arst_n = 1'b1;
      @(posedge sys_clk);
      #2;
      if (req_ready !== 1'b1 || rsp_valid !== 1'b0) begin
         $display("Bus handshake was not idle after reset");
         abort_run();
      end
      check_pins(gpio_out, '0, "gpio_out");
      check_pins(gpio_oe, '0, "gpio_oe");
      check_irq(gpio_irq, 1'b0);

      // One access at a time with occasional pin changes
      timed = 1'b1;
      for (int i = 0; i < N_SERIAL; i++) begin
         r = next_rand();
         if (r[2:0] == 3'd0) begin
            change_pins(r[31:16]);
            check_irq(gpio_irq, |(m_stat & m_mask));
            send_req(1'b0, OFF_IRQ_STAT, '0);
            drain();
         end
         r = next_rand();
         send_req(r[4], r[3:0], next_rand());
         drain();
         check_pins(gpio_out, m_out, "gpio_out");
         check_pins(gpio_oe, m_dir, "gpio_oe");
         check_irq(gpio_irq, |(m_stat & m_mask));
      end

      // Back to back under response stalls
      timed = 1'b0;
      @(negedge sys_clk);
      stall_en = 1'b1;
      @(posedge sys_clk);
      #2;
      for (int i = 0; i < N_STALL; i++)
         stream_one();
      @(negedge sys_clk);
      stall_en = 1'b0;
      drain();

      // Back to back, latency fixed
      timed = 1'b1;
      for (int i = 0; i < N_TIMED; i++)
         stream_one();
      drain();
      check_pins(gpio_out, m_out, "gpio_out");
      check_pins(gpio_oe, m_dir, "gpio_oe");
      $display("Finished with no errors");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
      abort_run();
   end

endmodule

// File: gpio_top.f
+incdir+bench
source/gpio_reg_pkg.sv
source/gpio_bus_pkg.sv
source/gpio_cmd_if.sv
source/gpio_cmd_stage.sv
source/gpio_in_sync.sv
source/gpio_regfile.sv
source/gpio_rsp_stage.sv
source/gpio_top.sv
bench/gpio_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the GPIO controller testbench with Verilator

rm -rf obj_dir sim.log
verilator --binary --timing -f gpio_top.f --top-module gpio_top_tb -o gpio_sim \
   || { echo "Build failed"; exit 1; }
./obj_dir/gpio_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"

// File: source/gpio_bus_pkg.sv
/* Register bus definitions: request address and data widths, response status */

package gpio_bus_pkg;

   //########################################
   // Bus geometry
   //########################################
   localparam int ADDR_W = 4;                    // Word address bits
   localparam int DATA_W = 32;                   // Data bits, upper ones read zero

   //########################################
   // Response status
   //########################################
   typedef enum logic {
      RESP_OK  = 1'b0,                           // Access done
      RESP_ERR = 1'b1                            // Bad offset or illegal direction
   } gpio_resp_e;

   // Request and response both use valid/ready
   // A beat moves on an edge with valid and ready high
   // The sender holds valid and payload until then

endpackage

// File: source/gpio_cmd_if.sv
/* Decoded command between the request stage and the register file */

`timescale 1ns/1ps

interface gpio_cmd_if
   import gpio_reg_pkg::*, gpio_bus_pkg::*;
   ();

   logic              valid;                     // Command present
   logic              ready;                     // Register file can execute
   logic              write;                     // 1 write, 0 read
   gpio_reg_e         reg_sel;                   // Decoded target
   logic [DATA_W-1:0] wdata;                     // Write data, full bus width

   // Request stage side
   modport src (
      output valid,
      input  ready,
      output write,
      output reg_sel,
      output wdata
   );

   // Register file side
   modport dst (
      input  valid,
      output ready,
      input  write,
      input  reg_sel,
      input  wdata
   );

endinterface

// File: source/gpio_cmd_stage.sv
/* Request stage: two-entry skid buffer on the bus request, word address decoded
   into a register operation on the way in */

`timescale 1ns/1ps

module gpio_cmd_stage
   import gpio_reg_pkg::*, gpio_bus_pkg::*;
   (
   input  logic              sys_clk,
   input  logic              arst_n,
   input  logic              req_valid,
   output logic              req_ready,
   input  logic              req_write,
   input  logic [ADDR_W-1:0] req_addr,
   input  logic [DATA_W-1:0] req_wdata,
   gpio_cmd_if.src           cmd
   );

   logic              write_q [2];               // Entry direction
   gpio_reg_e         sel_q   [2];               // Entry target
   logic [DATA_W-1:0] wdata_q [2];               // Entry write data
   logic              wr_ptr;                    // Next free entry
   logic              rd_ptr;                    // Oldest entry
   logic [1:0]        count;                     // Entries held, 0..2
   logic              push;
   logic              pop;

   //########################################
   // Address decode
   //########################################
   function automatic gpio_reg_e decode_addr(input logic [ADDR_W-1:0] addr);
      gpio_reg_e sel;
      case (addr)
         OFF_OUT:      sel = REG_OUT;
         OFF_OUT_SET:  sel = REG_OUT_SET;
         OFF_OUT_CLR:  sel = REG_OUT_CLR;
         OFF_OUT_XOR:  sel = REG_OUT_XOR;
         OFF_DIR:      sel = REG_DIR;
         OFF_IN:       sel = REG_IN;
         OFF_IRQ_MASK: sel = REG_IRQ_MASK;
         OFF_IRQ_EDGE: sel = REG_IRQ_EDGE;
         OFF_IRQ_POL:  sel = REG_IRQ_POL;
         OFF_IRQ_STAT: sel = REG_IRQ_STAT;
         default:      sel = REG_BAD;            // Offsets above 9
      endcase
      return sel;
   endfunction

   //########################################
   // Skid buffer
   //########################################
   assign req_ready = (count != 2'd2);           // Registered count only, no path from cmd.ready
   assign push      = req_valid & req_ready;
   assign pop       = cmd.valid & cmd.ready;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (push)
            wr_ptr <= ~wr_ptr;                   // Two entries, pointer just flips
         if (pop)
            rd_ptr <= ~rd_ptr;
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;             // Idle or pass-through
         endcase
      end
   end

   // Payload storage
   always_ff @(posedge sys_clk) begin
      if (push) begin
         write_q[wr_ptr] <= req_write;
         sel_q[wr_ptr]   <= decode_addr(req_addr);
         wdata_q[wr_ptr] <= req_wdata;
      end
   end

   // Head of buffer drives the command
   assign cmd.valid   = (count != 2'd0);
   assign cmd.write   = write_q[rd_ptr];
   assign cmd.reg_sel = sel_q[rd_ptr];
   assign cmd.wdata   = wdata_q[rd_ptr];

endmodule

// File: source/gpio_in_sync.sv
/* Pin input synchronizer with per-pin rising and falling edge pulses */

`timescale 1ns/1ps

module gpio_in_sync
   import gpio_reg_pkg::*;
   (
   input  logic      sys_clk,
   input  logic      arst_n,
   input  gpio_vec_t pins,                       // Asynchronous pin levels
   output gpio_vec_t level,                      // Synced level
   output gpio_vec_t rise,                       // One cycle on 0 to 1
   output gpio_vec_t fall                        // One cycle on 1 to 0
   );

   gpio_vec_t meta_q;                            // First flop, may go metastable
   gpio_vec_t sync_q;                            // Second flop, safe to use
   gpio_vec_t prev_q;                            // Synced level one cycle back

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         meta_q <= '0;
         sync_q <= '0;
         prev_q <= '0;
      end else begin
         meta_q <= pins;
         sync_q <= meta_q;
         prev_q <= sync_q;
      end
   end

   assign level = sync_q;
   assign rise  = sync_q & ~prev_q;              // Visible with the new level
   assign fall  = ~sync_q & prev_q;

endmodule

// File: source/gpio_reg_pkg.sv
/* GPIO register map: pin count, register operation encoding and word offsets
   shared by the decoder, the register file and the pin logic */

package gpio_reg_pkg;

   //########################################
   // Port geometry
   //########################################
   localparam int NGPIO = 16;                    // Pins on the port

   typedef logic [NGPIO-1:0] gpio_vec_t;         // One bit per pin

   //########################################
   // Register operations
   //########################################
   typedef enum logic [3:0] {
      REG_OUT      = 4'd0,                       // Output data
      REG_OUT_SET  = 4'd1,                       // Set bits in OUT, write only
      REG_OUT_CLR  = 4'd2,                       // Clear bits in OUT, write only
      REG_OUT_XOR  = 4'd3,                       // Toggle bits in OUT, write only
      REG_DIR      = 4'd4,                       // Output enable, 1 drives
      REG_IN       = 4'd5,                       // Synced pin level, read only
      REG_IRQ_MASK = 4'd6,                       // Per-pin interrupt enable
      REG_IRQ_EDGE = 4'd7,                       // 1 edge, 0 level
      REG_IRQ_POL  = 4'd8,                       // 1 rise/high, 0 fall/low
      REG_IRQ_STAT = 4'd9,                       // Event status, W1C
      REG_BAD      = 4'd15                       // Unmapped offset
   } gpio_reg_e;

   //########################################
   // Word offsets
   //########################################
   localparam logic [3:0] OFF_OUT      = 4'd0;
   localparam logic [3:0] OFF_OUT_SET  = 4'd1;
   localparam logic [3:0] OFF_OUT_CLR  = 4'd2;
   localparam logic [3:0] OFF_OUT_XOR  = 4'd3;
   localparam logic [3:0] OFF_DIR      = 4'd4;
   localparam logic [3:0] OFF_IN       = 4'd5;
   localparam logic [3:0] OFF_IRQ_MASK = 4'd6;
   localparam logic [3:0] OFF_IRQ_EDGE = 4'd7;
   localparam logic [3:0] OFF_IRQ_POL  = 4'd8;
   localparam logic [3:0] OFF_IRQ_STAT = 4'd9;  // Highest mapped offset

endpackage

// File: source/gpio_regfile.sv
/* Execute stage: GPIO register file with read/write decode, output registers
   and the per-pin interrupt status and request logic */

`timescale 1ns/1ps

module gpio_regfile
   import gpio_reg_pkg::*, gpio_bus_pkg::*;
   (
   input  logic              sys_clk,
   input  logic              arst_n,
   gpio_cmd_if.dst           cmd,
   input  gpio_vec_t         level,
   input  gpio_vec_t         rise,
   input  gpio_vec_t         fall,
   output logic              res_valid,
   input  logic              res_ready,
   output logic [DATA_W-1:0] res_rdata,
   output gpio_resp_e        res_err,
   output gpio_vec_t         out_reg,
   output gpio_vec_t         dir_reg,
   output logic              irq
   );

   gpio_vec_t  mask_q;                           // Interrupt enable
   gpio_vec_t  edge_q;                           // Edge/level select
   gpio_vec_t  pol_q;                            // Polarity
   gpio_vec_t  stat_q;                           // Event status
   gpio_vec_t  stat_set;                         // Events this cycle
   gpio_vec_t  stat_clr;                         // W1C bits this cycle
   gpio_vec_t  wr_bits;                          // Pin part of write data
   gpio_vec_t  rd_val;                           // Read mux
   gpio_resp_e rd_err;
   gpio_resp_e wr_err;
   logic       exec;                             // Command executes this cycle
   logic       wr_en;

   //########################################
   // Handshake
   //########################################
   assign res_valid = cmd.valid;                 // Result is combinational
   assign cmd.ready = res_ready;                 // Stall only on response side
   assign exec      = cmd.valid & res_ready;
   assign wr_en     = exec & cmd.write;
   assign wr_bits   = cmd.wdata[NGPIO-1:0];      // Upper data bits ignored

   //########################################
   // Read mux and status
   //########################################
   always_comb begin
      rd_val = '0;
      rd_err = RESP_OK;
      case (cmd.reg_sel)
         REG_OUT:      rd_val = out_reg;
         REG_DIR:      rd_val = dir_reg;
         REG_IN:       rd_val = level;
         REG_IRQ_MASK: rd_val = mask_q;
         REG_IRQ_EDGE: rd_val = edge_q;
         REG_IRQ_POL:  rd_val = pol_q;
         REG_IRQ_STAT: rd_val = stat_q;
         default:      rd_err = RESP_ERR;        // SET/CLR/XOR and bad offset
      endcase
   end

   // Input register and unmapped offsets refuse writes
   always_comb begin
      if (cmd.reg_sel == REG_IN || cmd.reg_sel == REG_BAD)
         wr_err = RESP_ERR;
      else
         wr_err = RESP_OK;
   end

   always_comb begin
      if (cmd.write) begin
         res_rdata = '0;                         // Writes return zero
         res_err   = wr_err;
      end else begin
         res_rdata = {{(DATA_W-NGPIO){1'b0}}, rd_val};
         res_err   = rd_err;
      end
   end

   //########################################
   // Register writes
   //########################################
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         out_reg <= '0;
         dir_reg <= '0;
         mask_q  <= '0;
         edge_q  <= '0;
         pol_q   <= '0;
      end else if (wr_en) begin
         case (cmd.reg_sel)
            REG_OUT:      out_reg <= wr_bits;
            REG_OUT_SET:  out_reg <= out_reg | wr_bits;
            REG_OUT_CLR:  out_reg <= out_reg & ~wr_bits;
            REG_OUT_XOR:  out_reg <= out_reg ^ wr_bits;
            REG_DIR:      dir_reg <= wr_bits;
            REG_IRQ_MASK: mask_q  <= wr_bits;
            REG_IRQ_EDGE: edge_q  <= wr_bits;
            REG_IRQ_POL:  pol_q   <= wr_bits;
            default:      ;                      // IN, STAT, bad: nothing here
         endcase
      end
   end

   //########################################
   // Interrupt status
   //########################################
   // Edge pins take the pulse picked by polarity, level pins the match
   assign stat_set = (edge_q & ((pol_q & rise) | (~pol_q & fall)))
                   | (~edge_q & ~(level ^ pol_q));

   assign stat_clr = (wr_en && cmd.reg_sel == REG_IRQ_STAT) ? wr_bits : '0;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         stat_q <= '0;
         irq    <= 1'b0;
      end else begin
         stat_q <= (stat_q & ~stat_clr) | stat_set;  // New event beats a clear
         irq    <= |(stat_q & mask_q);               // One edge after status
      end
   end

endmodule

// File: source/gpio_rsp_stage.sv
/* Response register: one entry, loads when empty or draining, holds under stall */

`timescale 1ns/1ps

module gpio_rsp_stage
   import gpio_bus_pkg::*;
   (
   input  logic              sys_clk,
   input  logic              arst_n,
   input  logic              res_valid,
   output logic              res_ready,
   input  logic [DATA_W-1:0] res_rdata,
   input  gpio_resp_e        res_err,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output logic [DATA_W-1:0] rsp_rdata,
   output logic              rsp_err
   );

   logic              full_q;                    // Entry holds a response
   logic [DATA_W-1:0] data_q;
   gpio_resp_e        err_q;
   logic              load;

   assign res_ready = ~full_q | rsp_ready;       // Free now or free at this edge
   assign load      = res_valid & res_ready;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n)
         full_q <= 1'b0;
      else if (load)
         full_q <= 1'b1;                         // Refill, even while draining
      else if (rsp_ready)
         full_q <= 1'b0;
   end

   // Payload held while rsp_ready is low
   always_ff @(posedge sys_clk) begin
      if (load) begin
         data_q <= res_rdata;
         err_q  <= res_err;
      end
   end

   assign rsp_valid = full_q;
   assign rsp_rdata = data_q;
   assign rsp_err   = (err_q == RESP_ERR);

endmodule

// File: source/gpio_top.sv
/* GPIO controller top: register bus pipeline, output registers, input
   synchronizer and interrupt unit on a 16-pin port */

`timescale 1ns/1ps

module gpio_top
   import gpio_reg_pkg::*, gpio_bus_pkg::*;
   (
   input  logic              sys_clk,         // System clock
   input  logic              arst_n,          // Async reset, active low
   // Request channel
   input  logic              req_valid,
   output logic              req_ready,
   input  logic              req_write,
   input  logic [ADDR_W-1:0] req_addr,        // Word offset
   input  logic [DATA_W-1:0] req_wdata,
   // Response channel
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output logic [DATA_W-1:0] rsp_rdata,
   output logic              rsp_err,
   // Pins
   input  gpio_vec_t         gpio_in,
   output gpio_vec_t         gpio_out,
   output gpio_vec_t         gpio_oe,         // 1 drives the pin
   output logic              gpio_irq
   );

   gpio_vec_t         pin_level;
   gpio_vec_t         pin_rise;
   gpio_vec_t         pin_fall;
   logic              res_valid;
   logic              res_ready;
   logic [DATA_W-1:0] res_rdata;
   gpio_resp_e        res_err;

   gpio_cmd_if cmd_if ();                     // Decode to execute

   //########################################
   // Bus pipeline
   //########################################
   gpio_cmd_stage u_cmd (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .cmd       (cmd_if.src)
   );

   gpio_regfile u_regs (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .cmd       (cmd_if.dst),
      .level     (pin_level),
      .rise      (pin_rise),
      .fall      (pin_fall),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_rdata (res_rdata),
      .res_err   (res_err),
      .out_reg   (gpio_out),                  // Pin data straight from OUT
      .dir_reg   (gpio_oe),
      .irq       (gpio_irq)
   );

   gpio_rsp_stage u_rsp (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_rdata (res_rdata),
      .res_err   (res_err),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata),
      .rsp_err   (rsp_err)
   );

   //########################################
   // Pin input
   //########################################
   gpio_in_sync u_sync (
      .sys_clk (sys_clk),
      .arst_n  (arst_n),
      .pins    (gpio_in),
      .level   (pin_level),
      .rise    (pin_rise),
      .fall    (pin_fall)
   );

endmodule
